// ==== Makefile ====
# Verilator simulation of the machine CSR block

TOP       ?= machine_csr_tb
FILELIST  ?= machine_csr_top.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== hw/csr_file.sv ====
// Reads bypass trap updates only, since the software write is derived from this same read
`timescale 1ns/1ps
`default_nettype none

module csr_file import csr_pkg::*; (
  input  wire                    clk,
  input  wire                    rst,
  input  wire csr_addr_t         rd_addr,
  output logic [xlen_w-1:0]      rd_data,
  input  wire                    wr_en,
  input  wire [xlen_w-1:0]       wr_data,
  input  wire trap_upd_t         upd,
  output trap_view_t             view,
  output logic                   illegal
);

  mstatus_u          mstatus_q;
  logic [xlen_w-1:0] mie_q;
  logic [xlen_w-1:0] mtvec_q;
  logic [xlen_w-1:0] mscratch_q;
  logic [xlen_w-1:0] mepc_q;
  logic [xlen_w-1:0] mcause_q;
  logic [xlen_w-1:0] mtval_q;
  logic [xlen_w-1:0] mip_q;
  logic [xlen_w-1:0] mcycle_q;

  logic              known;         // Address maps to an implemented CSR
  logic              read_only;
  logic              illegal_raw;
  logic              wr_ok;
  logic              trap_mstatus;
  logic [xlen_w-1:0] rd_raw;

  assign read_only    = (rd_addr[11:10] == 2'b11);
  assign illegal_raw  = ~known | (wr_en & read_only);
  assign wr_ok        = wr_en & ~illegal_raw;   // Flagged writes are dropped
  assign trap_mstatus = upd.enter | upd.leave;

  // mstatus is touched by both trap entry and trap return
  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q.raw <= MSTATUS_RST;
    end else if (trap_mstatus) begin
      mstatus_q <= upd.mstatus;
    end else if (wr_ok && (rd_addr == CSR_MSTATUS)) begin
      mstatus_q.raw <= wr_data;
    end
  end

  // Trap entry registers, trap update has priority over software
  always_ff @(posedge clk) begin
    if (rst) begin
      mepc_q   <= '0;
      mcause_q <= '0;
      mtval_q  <= '0;
    end else if (upd.enter) begin
      mepc_q   <= upd.mepc;
      mcause_q <= upd.mcause;
      mtval_q  <= upd.mtval;
    end else if (wr_ok) begin
      case (rd_addr)
        CSR_MEPC:   mepc_q   <= wr_data;
        CSR_MCAUSE: mcause_q <= wr_data;
        CSR_MTVAL:  mtval_q  <= wr_data;
        default: begin
        end
      endcase
    end
  end

  // Software-only registers
  always_ff @(posedge clk) begin
    if (rst) begin
      mie_q      <= MIE_RST;
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mip_q      <= MIP_RST;
    end else if (wr_ok) begin
      case (rd_addr)
        CSR_MIE:      mie_q      <= wr_data;
        CSR_MTVEC:    mtvec_q    <= wr_data;
        CSR_MSCRATCH: mscratch_q <= wr_data;
        CSR_MIP:      mip_q      <= wr_data;  // No hardware interrupt sources
        default: begin
        end
      endcase
    end
  end

  // Free-running cycle counter, a write replaces the increment
  always_ff @(posedge clk) begin
    if (rst) begin
      mcycle_q <= '0;
    end else if (wr_ok && (rd_addr == CSR_MCYCLE)) begin
      mcycle_q <= wr_data;
    end else begin
      mcycle_q <= mcycle_q + 64'd1;
    end
  end

  // Read mux and address decode
  always_comb begin
    known  = 1'b1;
    rd_raw = '0;
    case (rd_addr)
      CSR_MSTATUS: begin
        rd_raw = trap_mstatus ? upd.mstatus.raw : mstatus_q.raw;
      end
      CSR_MISA:     rd_raw = MISA_VAL;
      CSR_MIE:      rd_raw = mie_q;
      CSR_MTVEC:    rd_raw = mtvec_q;
      CSR_MSCRATCH: rd_raw = mscratch_q;
      CSR_MEPC:     rd_raw = upd.enter ? upd.mepc : mepc_q;
      CSR_MCAUSE:   rd_raw = upd.enter ? upd.mcause : mcause_q;
      CSR_MTVAL:    rd_raw = upd.enter ? upd.mtval : mtval_q;
      CSR_MIP:      rd_raw = mip_q;
      CSR_MCYCLE:   rd_raw = mcycle_q;
      CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID: begin
        rd_raw = '0;  // ID registers read as zero
      end
      default: begin
        known = 1'b0;
      end
    endcase
  end

  // Outputs held inactive while in reset
  assign rd_data = rst ? '0 : rd_raw;
  assign illegal = ~rst & illegal_raw;

  // Stored values for the trap controller
  assign view = '{mstatus: mstatus_q, mtvec: mtvec_q, mepc: mepc_q};

endmodule

`default_nettype wire

// ==== hw/csr_op_unit.sv ====
// old_data must be the pre-write value at req.addr, and legality of the write is judged by the CSR file
`timescale 1ns/1ps
`default_nettype none

module csr_op_unit import csr_pkg::*; (
  input  wire csr_req_t          req,
  input  wire [xlen_w-1:0]       old_data,
  output logic                   wr_en,
  output logic [xlen_w-1:0]      wr_data
);

  logic src_zero;
  logic is_rw;

  assign src_zero = (req.src == '0);
  assign is_rw    = (req.op == OP_RW);

  // New value for each instruction form
  always_comb begin
    case (req.op)
      OP_RS: begin
        wr_data = old_data | req.src;   // csrrs
      end
      OP_RC: begin
        wr_data = old_data & ~req.src;  // csrrc
      end
      default: begin
        wr_data = req.src;              // csrrw
      end
    endcase
  end

  // Set or clear with a zero mask is a pure read
  // This keeps reads of the ID registers legal
  always_comb begin
    wr_en = 1'b0;
    if (req.valid) begin
      if (is_rw) begin
        wr_en = 1'b1;
      end else begin
        wr_en = ~src_zero;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/csr_pkg.sv ====
// Machine mode only on RV64, direct trap vectors, no interrupt sources and no counters besides mcycle
`default_nettype none

package csr_pkg;

  localparam int unsigned xlen_w = 64;

  typedef logic [11:0] csr_addr_t;

  // Machine CSR addresses
  localparam csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam csr_addr_t CSR_MISA      = 12'h301;
  localparam csr_addr_t CSR_MIE       = 12'h304;
  localparam csr_addr_t CSR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
  localparam csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_MTVAL     = 12'h343;
  localparam csr_addr_t CSR_MIP       = 12'h344;
  localparam csr_addr_t CSR_MCYCLE    = 12'hB00;
  localparam csr_addr_t CSR_MVENDORID = 12'hF11;
  localparam csr_addr_t CSR_MARCHID   = 12'hF12;
  localparam csr_addr_t CSR_MIMPID    = 12'hF13;
  localparam csr_addr_t CSR_MHARTID   = 12'hF14;

  localparam logic [xlen_w-1:0] MSTATUS_RST = 64'h0000_0000_0000_1888;
  localparam logic [xlen_w-1:0] MIE_RST     = 64'h0000_0000_0000_0888;
  localparam logic [xlen_w-1:0] MIP_RST     = 64'h0000_0000_0000_0080;

  // MXL = 2 (64 bit), I extension only
  localparam logic [xlen_w-1:0] MISA_VAL    = 64'h8000_0000_0000_0100;

  localparam logic [1:0] PRIV_M = 2'b11;  // Machine privilege in MPP

  typedef enum logic [1:0] {
    OP_RW = 2'd1,
    OP_RS = 2'd2,
    OP_RC = 2'd3
  } csr_op_e;

  typedef struct packed {
    logic [50:0] rsvd_hi;   // Bits 63:13
    logic [1:0]  mpp;
    logic [2:0]  rsvd_mid;  // Bits 10:8
    logic        mpie;
    logic [2:0]  rsvd_lo;   // Bits 6:4
    logic        mie;
    logic [2:0]  rsvd_bot;  // Bits 2:0
  } mstatus_fld_t;

  // Same word, seen raw by software and by field in the trap logic
  typedef union packed {
    logic [xlen_w-1:0] raw;
    mstatus_fld_t      fld;
  } mstatus_u;

  typedef struct packed {
    logic              valid;
    csr_addr_t         addr;
    csr_op_e           op;
    logic [xlen_w-1:0] src;
  } csr_req_t;

  typedef struct packed {
    logic              enter;  // Exception taken
    logic              leave;  // mret
    logic [xlen_w-1:0] cause;
    logic [xlen_w-1:0] pc;
    logic [xlen_w-1:0] tval;
  } trap_req_t;

  typedef struct packed {
    mstatus_u          mstatus;
    logic [xlen_w-1:0] mtvec;
    logic [xlen_w-1:0] mepc;
  } trap_view_t;

  typedef struct packed {
    logic              enter;
    logic              leave;
    mstatus_u          mstatus;
    logic [xlen_w-1:0] mepc;
    logic [xlen_w-1:0] mcause;
    logic [xlen_w-1:0] mtval;
  } trap_upd_t;

endpackage

`default_nettype wire

// ==== hw/machine_csr_top.sv ====
// Accepts one CSR request and one trap event per cycle, with no handshake and no back-pressure
`timescale 1ns/1ps
`default_nettype none

module machine_csr_top import csr_pkg::*; (
  input  wire                    clk,
  input  wire                    rst,
  input  wire csr_req_t          req,
  input  wire trap_req_t         trap,
  output logic [xlen_w-1:0]      rd_data,
  output logic                   illegal,
  output logic                   redirect_valid,
  output logic [xlen_w-1:0]      redirect_pc
);

  logic              wr_en;
  logic [xlen_w-1:0] wr_data;
  trap_view_t        view;
  trap_upd_t         upd;
  logic              trap_redirect;

  csr_op_unit u_op (
    .req      (req),
    .old_data (rd_data),  // Old value feeds the set and clear forms
    .wr_en    (wr_en),
    .wr_data  (wr_data)
  );

  trap_ctrl u_trap (
    .trap           (trap),
    .view           (view),
    .upd            (upd),
    .redirect_valid (trap_redirect),
    .redirect_pc    (redirect_pc)
  );

  csr_file u_csr (
    .clk     (clk),
    .rst     (rst),
    .rd_addr (req.addr),
    .rd_data (rd_data),
    .wr_en   (wr_en),
    .wr_data (wr_data),
    .upd     (upd),
    .view    (view),
    .illegal (illegal)
  );

  assign redirect_valid = trap_redirect & ~rst;  // No redirect during reset

endmodule

`default_nettype wire

// ==== hw/trap_ctrl.sv ====
// Direct trap mode only, enter and leave are one-hot per cycle and MPP is always machine mode
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl import csr_pkg::*; (
  input  wire trap_req_t         trap,
  input  wire trap_view_t        view,
  output trap_upd_t              upd,
  output logic                   redirect_valid,
  output logic [xlen_w-1:0]      redirect_pc
);

  mstatus_u          mstatus_nxt;
  logic [xlen_w-1:0] vec_base;

  // Low two bits of mtvec hold the mode field
  assign vec_base = {view.mtvec[xlen_w-1:2], 2'b00};

  // mstatus after the trap event
  always_comb begin
    mstatus_nxt = view.mstatus;
    if (trap.enter) begin
      mstatus_nxt.fld.mpie = view.mstatus.fld.mie;  // Stack the enable
      mstatus_nxt.fld.mie  = 1'b0;
      mstatus_nxt.fld.mpp  = PRIV_M;
    end else if (trap.leave) begin
      mstatus_nxt.fld.mie  = view.mstatus.fld.mpie;
      mstatus_nxt.fld.mpie = 1'b1;
      mstatus_nxt.fld.mpp  = PRIV_M;                 // No lower mode to drop to
    end
  end

  // Register updates, applied by the CSR file only on enter or leave
  always_comb begin
    upd.enter   = trap.enter;
    upd.leave   = trap.leave;
    upd.mstatus = mstatus_nxt;
    upd.mepc    = trap.pc;
    upd.mcause  = trap.cause;
    upd.mtval   = trap.tval;
  end

  // Pipeline redirect for both events
  always_comb begin
    redirect_valid = trap.enter | trap.leave;
    if (trap.enter) begin
      redirect_pc = vec_base;
    end else begin
      redirect_pc = view.mepc;  // Return target
    end
  end

endmodule

`default_nettype wire

// ==== machine_csr_top.f ====
hw/csr_pkg.sv
hw/csr_op_unit.sv
hw/trap_ctrl.sv
hw/csr_file.sv
hw/machine_csr_top.sv
tb/machine_csr_tb.sv

// ==== tb/machine_csr_tb.sv ====
// Single hart, machine mode only; mcycle is checked by ordering and exact write-back, not by a model
`timescale 1ns/1ps
`default_nettype none

module machine_csr_tb import csr_pkg::*;;

  localparam int clk_period  = 4;
  localparam int n_rand      = 40;
  localparam int planned_req = n_rand + 45;  // Reset, directed reads, writes and idles

  logic              clk;
  logic              rst;
  csr_req_t          req;
  trap_req_t         trap;
  logic [xlen_w-1:0] rd_data;
  logic              illegal;
  logic              redirect_valid;
  logic [xlen_w-1:0] redirect_pc;

  logic [xlen_w-1:0] model [0:4095];  // Shadow CSR values by address
  int                errors;
  int                prop_errors;

  machine_csr_top u_dut (
    .clk            (clk),
    .rst            (rst),
    .req            (req),
    .trap           (trap),
    .rd_data        (rd_data),
    .illegal        (illegal),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Redirect only follows a trap event, and all outputs stay quiet in reset
  assert property (@(posedge clk) disable iff (rst) redirect_valid == (trap.enter | trap.leave))
    else begin
      prop_errors++;
      $display("ERROR redirect_valid: expected %0b, actual %0b", trap.enter | trap.leave,
               redirect_valid);
    end
  assert property (@(posedge clk) rst |-> (!redirect_valid && !illegal && rd_data == '0))
    else begin
      prop_errors++;
      $display("Outputs were active while reset was high");
    end

  initial begin
    #(planned_req * clk_period * 2);
    $display("Timeout: the test sequence did not finish in time");
    $display(">>> FAIL");
    $finish;
  end

  function automatic logic is_known(csr_addr_t a);
    case (a)
      CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE,
      CSR_MTVAL, CSR_MIP, CSR_MCYCLE, CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID,
      CSR_MHARTID: return 1'b1;
      default:     return 1'b0;
    endcase
  endfunction

  function automatic logic [xlen_w-1:0] new_value(csr_op_e op, logic [xlen_w-1:0] old,
                                                  logic [xlen_w-1:0] src);
    case (op)
      OP_RS:   return old | src;
      OP_RC:   return old & ~src;
      default: return src;
    endcase
  endfunction

  // MPIE takes MIE, MIE clears, MPP goes to machine
  function automatic logic [xlen_w-1:0] entry_mstatus(logic [xlen_w-1:0] m);
    logic [xlen_w-1:0] r;
    r        = m;
    r[7]     = m[3];
    r[3]     = 1'b0;
    r[12:11] = 2'b11;
    return r;
  endfunction

  function automatic logic [xlen_w-1:0] return_mstatus(logic [xlen_w-1:0] m);
    logic [xlen_w-1:0] r;
    r        = m;
    r[3]     = m[7];
    r[7]     = 1'b1;
    r[12:11] = 2'b11;
    return r;
  endfunction

  task automatic compare_word(input string name, input logic [xlen_w-1:0] exp,
                              input logic [xlen_w-1:0] act);
    assert (act === exp) else begin
      errors++;
      $display("ERROR %s: expected 0x%h, actual 0x%h", name, exp, act);
    end
  endtask

  task automatic verify_flag(input string name, input logic exp, input logic act);
    assert (act === exp) else begin
      errors++;
      $display("ERROR %s: expected %0b, actual %0b", name, exp, act);
    end
  endtask

  // Idle cycles park the address on a known CSR
  task automatic go_idle(input int n);
    repeat (n) begin
      @(negedge clk);
      req  = '{valid: 1'b0, addr: CSR_MSCRATCH, op: OP_RS, src: '0};
      trap = '0;
    end
  endtask

  task automatic drive_req(input csr_addr_t addr, input csr_op_e op, input logic [xlen_w-1:0] src);
    @(negedge clk);
    req  = '{valid: 1'b1, addr: addr, op: op, src: src};
    trap = '0;
    #1;  // Let the combinational outputs settle
  endtask

  // One instruction checked against the shadow model, then the model is updated
  task automatic csr_access(input string name, input csr_addr_t addr, input csr_op_e op,
                            input logic [xlen_w-1:0] src);
    logic              known;
    logic              we;
    logic              exp_ill;
    logic [xlen_w-1:0] exp_rd;
    known   = is_known(addr);
    exp_rd  = known ? model[addr] : '0;
    we      = (op == OP_RW) || (src != '0);
    exp_ill = !known || (we && addr[11:10] == 2'b11);
    drive_req(addr, op, src);
    compare_word(name, exp_rd, rd_data);
    verify_flag({name, " illegal"}, exp_ill, illegal);
    if (we && !exp_ill && addr != CSR_MISA) begin
      model[addr] = new_value(op, exp_rd, src);
    end
  endtask

  task automatic enter_trap(input logic [xlen_w-1:0] cause, input logic [xlen_w-1:0] pc,
                            input logic [xlen_w-1:0] tval, input logic [xlen_w-1:0] sw_src);
    @(negedge clk);
    req  = '{valid: 1'b1, addr: CSR_MEPC, op: OP_RW, src: sw_src};  // Competing mepc write
    trap = '{enter: 1'b1, leave: 1'b0, cause: cause, pc: pc, tval: tval};
    #1;
    compare_word("trap entry redirect", {model[CSR_MTVEC][63:2], 2'b00}, redirect_pc);
    compare_word("trap entry mepc bypass", pc, rd_data);
    verify_flag("trap entry illegal", 1'b0, illegal);
    model[CSR_MEPC]    = pc;
    model[CSR_MCAUSE]  = cause;
    model[CSR_MTVAL]   = tval;
    model[CSR_MSTATUS] = entry_mstatus(model[CSR_MSTATUS]);
  endtask

  task automatic return_trap();
    @(negedge clk);
    req  = '{valid: 1'b1, addr: CSR_MSTATUS, op: OP_RS, src: '0};
    trap = '{enter: 1'b0, leave: 1'b1, cause: '0, pc: '0, tval: '0};
    #1;
    model[CSR_MSTATUS] = return_mstatus(model[CSR_MSTATUS]);
    compare_word("trap return redirect", model[CSR_MEPC], redirect_pc);
    compare_word("trap return mstatus bypass", model[CSR_MSTATUS], rd_data);
  endtask

  initial begin
    logic [xlen_w-1:0] src;
    logic [xlen_w-1:0] cyc_a;
    logic [xlen_w-1:0] cyc_b;
    logic [1:0]        pick;
    csr_op_e           op;
    csr_addr_t         addr;
    void'($urandom(70));
    errors      = 0;
    prop_errors = 0;
    model       = '{default: '0};
    model[CSR_MSTATUS] = MSTATUS_RST;
    model[CSR_MIE]     = MIE_RST;
    model[CSR_MIP]     = MIP_RST;
    model[CSR_MISA]    = MISA_VAL;
    rst  = 1'b1;
    // Requests and a trap in reset that would drive every output if not held off
    req  = '{valid: 1'b1, addr: CSR_MISA, op: OP_RS, src: '0};
    trap = '{enter: 1'b1, leave: 1'b0, cause: '0, pc: '0, tval: '0};
    repeat (3) @(posedge clk);
    @(negedge clk);
    req  = '{valid: 1'b1, addr: 12'h7C0, op: OP_RW, src: 64'h55};  // Unknown address
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst  = 1'b0;
    req  = '{valid: 1'b0, addr: CSR_MSCRATCH, op: OP_RS, src: '0};
    trap = '0;

    // Reset values, read with a zero set mask
    csr_access("reset mstatus", CSR_MSTATUS, OP_RS, '0);
    csr_access("reset mie", CSR_MIE, OP_RS, '0);
    csr_access("reset mip", CSR_MIP, OP_RS, '0);
    csr_access("reset misa", CSR_MISA, OP_RS, '0);
    csr_access("reset mvendorid", CSR_MVENDORID, OP_RS, '0);
    csr_access("reset marchid", CSR_MARCHID, OP_RS, '0);
    csr_access("reset mimpid", CSR_MIMPID, OP_RS, '0);
    csr_access("reset mhartid", CSR_MHARTID, OP_RS, '0);
    csr_access("reset mtvec", CSR_MTVEC, OP_RS, '0);

    for (int i = 0; i < n_rand; i++) begin
      pick = 2'($urandom % 4);
      case (pick)
        2'd0:    addr = CSR_MSCRATCH;
        2'd1:    addr = CSR_MTVEC;
        2'd2:    addr = CSR_MIE;
        default: addr = CSR_MEPC;
      endcase
      case ($urandom % 3)
        0:       op = OP_RW;
        1:       op = OP_RS;
        default: op = OP_RC;
      endcase
      src = {$urandom, $urandom};
      if ($urandom % 5 == 0) src = '0;
      csr_access($sformatf("random op %0d", i), addr, op, src);
    end

    csr_access("unknown address", 12'h7C0, OP_RW, 64'h55);
    csr_access("write mvendorid", CSR_MVENDORID, OP_RW, 64'hDEAD);
    csr_access("mvendorid after write", CSR_MVENDORID, OP_RS, '0);
    csr_access("zero set on mhartid", CSR_MHARTID, OP_RS, '0);

    // Clear MPIE first so the entry rule shows a visible change
    csr_access("setup mtvec", CSR_MTVEC, OP_RW, 64'h0000_0000_8000_1003);
    csr_access("setup mstatus", CSR_MSTATUS, OP_RC, 64'h80);
    enter_trap(64'd2, 64'h0000_0000_8000_0444, 64'h0000_0000_0BAD_C0DE, 64'h1234);
    csr_access("mepc after entry", CSR_MEPC, OP_RS, '0);
    csr_access("mcause after entry", CSR_MCAUSE, OP_RS, '0);
    csr_access("mtval after entry", CSR_MTVAL, OP_RS, '0);
    csr_access("mstatus after entry", CSR_MSTATUS, OP_RS, '0);
    // MIE set with MPIE clear so both return bits flip
    csr_access("setup mstatus for return", CSR_MSTATUS, OP_RW, 64'h1808);
    return_trap();
    csr_access("mstatus after return", CSR_MSTATUS, OP_RS, '0);

    drive_req(CSR_MCYCLE, OP_RS, '0);
    cyc_a = rd_data;
    go_idle(4);
    drive_req(CSR_MCYCLE, OP_RS, '0);
    cyc_b = rd_data;
    assert (cyc_b > cyc_a) else begin
      errors++;
      $display("mcycle did not advance across idle cycles");
    end
    drive_req(CSR_MCYCLE, OP_RW, 64'h1000_0000);
    verify_flag("mcycle write illegal", 1'b0, illegal);
    drive_req(CSR_MCYCLE, OP_RS, '0);
    compare_word("mcycle after write", 64'h1000_0000, rd_data);
    drive_req(CSR_MCYCLE, OP_RS, '0);
    compare_word("mcycle next cycle", 64'h1000_0001, rd_data);
    go_idle(2);

    $display("Errors: checks %0d, properties %0d", errors, prop_errors);
    if (errors + prop_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
